//--- files.f
+incdir+rtl
rtl/rob_types_pkg.sv
rtl/rob_msg_pkg.sv
rtl/rob_thread_queue.sv
rtl/rob_commit_select.sv
rtl/rob_top.sv
test/rob_properties.sv
test/rob_tb.sv

//--- rtl/rob_commit_select.sv
`timescale 1ns/1ps
`default_nettype none

module rob_commit_select (
	input wire rob_msg_pkg::rob_entry_t head0_t0,
	input wire rob_msg_pkg::rob_entry_t head1_t0,
	input wire rob_msg_pkg::rob_entry_t head0_t1,
	input wire rob_msg_pkg::rob_entry_t head1_t1,

	output rob_msg_pkg::commit_t commit0,
	output rob_msg_pkg::commit_t commit1,

	output rob_types_pkg::retire_cnt_t retire_t0,
	output rob_types_pkg::retire_cnt_t retire_t1,
	output logic flush_t0,
	output logic flush_t1
);

	logic ready0_t0;
	logic ready1_t0;
	logic ready0_t1;
	logic ready1_t1;

	logic redirect0; // slot 0 carries a mispredicted branch
	logic redirect1;

	function automatic rob_msg_pkg::commit_t to_commit(
		input rob_msg_pkg::rob_entry_t e,
		input logic thread
	);
		rob_msg_pkg::commit_t c;
		c.valid = 1'b1;
		c.thread = thread;
		c.pc = e.pc;
		c.target_pc = e.target_pc;
		c.arn = e.arn;
		c.prn = e.prn;
		c.is_branch = e.is_branch;
		c.mispredict = e.mispredict;
		return c;
	endfunction

	assign ready0_t0 = head0_t0.occupied & head0_t0.done;
	assign ready1_t0 = head1_t0.occupied & head1_t0.done;
	assign ready0_t1 = head0_t1.occupied & head0_t1.done;
	assign ready1_t1 = head1_t1.occupied & head1_t1.done;

	always_comb
	begin
		logic stop_same; // nothing younger of the slot 0 thread may follow
		commit0 = '0;
		commit1 = '0;

		// thread 0 has first pick
		if (ready0_t0)
			commit0 = to_commit(head0_t0, 1'b0);
		else if (ready0_t1)
			commit0 = to_commit(head0_t1, 1'b1);

		stop_same = commit0.is_branch & commit0.mispredict;

		if (commit0.valid)
		begin
			if (!commit0.thread && ready1_t0 && !stop_same)
				commit1 = to_commit(head1_t0, 1'b0);
			else if (commit0.thread && ready1_t1 && !stop_same)
				commit1 = to_commit(head1_t1, 1'b1);
			else if (!commit0.thread && ready0_t1)
				commit1 = to_commit(head0_t1, 1'b1); // fill from the other thread
		end
	end

	assign redirect0 = commit0.valid & commit0.is_branch & commit0.mispredict;
	assign redirect1 = commit1.valid & commit1.is_branch & commit1.mispredict;

	assign flush_t0 = (redirect0 & ~commit0.thread) | (redirect1 & ~commit1.thread);
	assign flush_t1 = (redirect0 & commit0.thread) | (redirect1 & commit1.thread);

	// one count per slot taken
	assign retire_t0 = rob_types_pkg::retire_cnt_t'(commit0.valid & ~commit0.thread)
		+ rob_types_pkg::retire_cnt_t'(commit1.valid & ~commit1.thread);
	assign retire_t1 = rob_types_pkg::retire_cnt_t'(commit0.valid & commit0.thread)
		+ rob_types_pkg::retire_cnt_t'(commit1.valid & commit1.thread);

endmodule

`default_nettype wire

//--- rtl/rob_consts.svh
`ifndef ROB_CONSTS_SVH
`define ROB_CONSTS_SVH

// entries held by each thread's queue
`define ROB_DEPTH 8
`define ROB_IDX_W 3

// datapath field widths
`define PC_W 64
`define ARN_W 5
`define PRN_W 6

// one bit picks the thread, two threads in flight
`define THREAD_W 1

// retire count per thread, 0 to 2
`define RETIRE_W 2

`endif

//--- rtl/rob_msg_pkg.sv
`default_nettype none

package rob_msg_pkg;

	// one instruction from rename, 77 bits
	typedef struct packed {
		logic valid;
		rob_types_pkg::pc_t pc;
		rob_types_pkg::arn_t arn;
		rob_types_pkg::prn_t prn;
		logic is_branch;
	} dispatch_inst_t;

	// functional unit writeback, 70 bits
	typedef struct packed {
		logic valid;
		rob_types_pkg::rob_tag_t tag;
		logic mispredict;
		rob_types_pkg::pc_t target_pc; // only meaningful with mispredict
	} complete_t;

	// stored per queue slot, 143 bits
	typedef struct packed {
		logic occupied;
		logic done;
		rob_types_pkg::pc_t pc;
		rob_types_pkg::arn_t arn;
		rob_types_pkg::prn_t prn;
		logic is_branch;
		logic mispredict;
		rob_types_pkg::pc_t target_pc;
	} rob_entry_t;

	// retirement record toward the RRAT and fetch, 143 bits
	typedef struct packed {
		logic valid;
		logic thread;
		rob_types_pkg::pc_t pc;
		rob_types_pkg::pc_t target_pc;
		rob_types_pkg::arn_t arn;
		rob_types_pkg::prn_t prn;
		logic is_branch;
		logic mispredict;
	} commit_t;

endpackage

`default_nettype wire

//--- rtl/rob_thread_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_consts.svh"

module rob_thread_queue #(
	parameter bit thread_id = 1'b0
) (
	input wire logic clock,
	input wire logic reset,

	input wire rob_msg_pkg::dispatch_inst_t dispatch0,
	input wire rob_msg_pkg::dispatch_inst_t dispatch1,
	input wire logic dispatch_sel, // this thread is the dispatch target

	input wire rob_msg_pkg::complete_t complete0,
	input wire rob_msg_pkg::complete_t complete1,

	input wire rob_types_pkg::retire_cnt_t retire_cnt,
	input wire logic flush,

	output rob_msg_pkg::rob_entry_t head_entry0,
	output rob_msg_pkg::rob_entry_t head_entry1,
	output rob_types_pkg::rob_idx_t tail_idx,
	output logic full
);

	rob_msg_pkg::rob_entry_t entries [`ROB_DEPTH];

	rob_types_pkg::rob_ptr_t head;
	rob_types_pkg::rob_ptr_t tail;
	rob_types_pkg::rob_ptr_t count; // entries in flight
	rob_types_pkg::rob_ptr_t head_after; // head once this cycle's retirements are gone

	rob_types_pkg::rob_idx_t head_idx;
	rob_types_pkg::rob_idx_t second_idx;
	rob_types_pkg::rob_idx_t tail_next_idx;

	rob_types_pkg::rob_idx_t done_idx0;
	rob_types_pkg::rob_idx_t done_idx1;

	logic accept0;
	logic accept1;
	logic hit0;
	logic hit1;

	function automatic rob_msg_pkg::rob_entry_t make_entry(
		input rob_msg_pkg::dispatch_inst_t d
	);
		rob_msg_pkg::rob_entry_t e;
		e.occupied = 1'b1;
		e.done = 1'b0;
		e.pc = d.pc;
		e.arn = d.arn;
		e.prn = d.prn;
		e.is_branch = d.is_branch;
		e.mispredict = 1'b0;
		e.target_pc = '0;
		return e;
	endfunction

	assign head_idx = head[`ROB_IDX_W-1:0];
	assign second_idx = head_idx + 3'd1;
	assign tail_idx = tail[`ROB_IDX_W-1:0];
	assign tail_next_idx = tail_idx + 3'd1;

	assign count = tail - head;
	assign head_after = head + rob_types_pkg::rob_ptr_t'(retire_cnt);

	// room must remain for a full pair
	assign full = (count > `ROB_DEPTH - 2);

	// a flushing thread drops its dispatch, the sender learns of it via commit
	assign accept0 = dispatch_sel & dispatch0.valid & ~full & ~flush;
	assign accept1 = accept0 & dispatch1.valid;

	assign done_idx0 = complete0.tag[`ROB_IDX_W-1:0];
	assign done_idx1 = complete1.tag[`ROB_IDX_W-1:0];

	// late writebacks for squashed slots are dropped by the occupied check
	assign hit0 = complete0.valid && (complete0.tag[`ROB_IDX_W] == thread_id)
		&& entries[done_idx0].occupied;
	assign hit1 = complete1.valid && (complete1.tag[`ROB_IDX_W] == thread_id)
		&& entries[done_idx1].occupied;

	always_comb
	begin
		head_entry0 = entries[head_idx];
		head_entry0.occupied = entries[head_idx].occupied && (count != '0);
		head_entry1 = entries[second_idx];
		head_entry1.occupied = entries[second_idx].occupied && (count > 1);
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			head <= '0;
			tail <= '0;
			for (int i = 0; i < `ROB_DEPTH; i++)
			begin
				entries[i].occupied <= 1'b0;
				entries[i].done <= 1'b0;
			end
		end
		else
		begin
			// port 1 first so port 0 overrides on a shared slot
			if (hit1)
			begin
				entries[done_idx1].done <= 1'b1;
				entries[done_idx1].mispredict <= complete1.mispredict;
				entries[done_idx1].target_pc <= complete1.target_pc;
			end
			if (hit0)
			begin
				entries[done_idx0].done <= 1'b1;
				entries[done_idx0].mispredict <= complete0.mispredict;
				entries[done_idx0].target_pc <= complete0.target_pc;
			end

			if (retire_cnt != '0)
				entries[head_idx].occupied <= 1'b0;
			if (retire_cnt == 2'd2)
				entries[second_idx].occupied <= 1'b0;
			head <= head_after;

			if (flush)
			begin
				// everything left behind the redirecting branch is wrong path
				tail <= head_after;
				for (int i = 0; i < `ROB_DEPTH; i++)
				begin
					entries[i].occupied <= 1'b0;
					entries[i].done <= 1'b0;
				end
			end
			else
			begin
				if (accept0)
					entries[tail_idx] <= make_entry(dispatch0);
				if (accept1)
					entries[tail_next_idx] <= make_entry(dispatch1);
				tail <= tail + rob_types_pkg::rob_ptr_t'(accept0)
					+ rob_types_pkg::rob_ptr_t'(accept1);
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/rob_top.sv
`timescale 1ns/1ps
`default_nettype none

module rob_top (
	input wire logic clock,
	input wire logic reset,

	input wire rob_msg_pkg::dispatch_inst_t dispatch0,
	input wire rob_msg_pkg::dispatch_inst_t dispatch1,
	input wire logic dispatch_thread,
	output rob_types_pkg::rob_tag_t tag0,
	output rob_types_pkg::rob_tag_t tag1,

	input wire rob_msg_pkg::complete_t complete0,
	input wire rob_msg_pkg::complete_t complete1,

	output rob_msg_pkg::commit_t commit0,
	output rob_msg_pkg::commit_t commit1,

	output logic full0,
	output logic full1
);

	rob_msg_pkg::rob_entry_t head0_t0;
	rob_msg_pkg::rob_entry_t head1_t0;
	rob_msg_pkg::rob_entry_t head0_t1;
	rob_msg_pkg::rob_entry_t head1_t1;

	rob_types_pkg::rob_idx_t tail_idx_t0;
	rob_types_pkg::rob_idx_t tail_idx_t1;
	rob_types_pkg::rob_idx_t sel_tail; // tail of the dispatch target

	rob_types_pkg::retire_cnt_t retire_t0;
	rob_types_pkg::retire_cnt_t retire_t1;
	logic flush_t0;
	logic flush_t1;

	assign sel_tail = dispatch_thread ? tail_idx_t1 : tail_idx_t0;
	assign tag0 = {dispatch_thread, sel_tail};
	assign tag1 = {dispatch_thread, sel_tail + 3'd1}; // wraps inside the thread

	rob_thread_queue #(.thread_id(1'b0)) queue_t0 (
		.clock(clock),
		.reset(reset),
		.dispatch0(dispatch0),
		.dispatch1(dispatch1),
		.dispatch_sel(~dispatch_thread),
		.complete0(complete0),
		.complete1(complete1),
		.retire_cnt(retire_t0),
		.flush(flush_t0),
		.head_entry0(head0_t0),
		.head_entry1(head1_t0),
		.tail_idx(tail_idx_t0),
		.full(full0)
	);

	rob_thread_queue #(.thread_id(1'b1)) queue_t1 (
		.clock(clock),
		.reset(reset),
		.dispatch0(dispatch0),
		.dispatch1(dispatch1),
		.dispatch_sel(dispatch_thread),
		.complete0(complete0),
		.complete1(complete1),
		.retire_cnt(retire_t1),
		.flush(flush_t1),
		.head_entry0(head0_t1),
		.head_entry1(head1_t1),
		.tail_idx(tail_idx_t1),
		.full(full1)
	);

	rob_commit_select select (
		.head0_t0(head0_t0),
		.head1_t0(head1_t0),
		.head0_t1(head0_t1),
		.head1_t1(head1_t1),
		.commit0(commit0),
		.commit1(commit1),
		.retire_t0(retire_t0),
		.retire_t1(retire_t1),
		.flush_t0(flush_t0),
		.flush_t1(flush_t1)
	);

endmodule

`default_nettype wire

//--- rtl/rob_types_pkg.sv
`default_nettype none

`include "rob_consts.svh"

package rob_types_pkg;

	typedef logic [`PC_W-1:0] pc_t;

	typedef logic [`ARN_W-1:0] arn_t; // architectural destination
	typedef logic [`PRN_W-1:0] prn_t; // physical destination

	// slot within one thread's queue
	typedef logic [`ROB_IDX_W-1:0] rob_idx_t;

	// extra wrap bit on top of the index tells full from empty
	typedef logic [`ROB_IDX_W:0] rob_ptr_t;

	// thread bit above the index, handed to the reservation stations
	typedef logic [`THREAD_W+`ROB_IDX_W-1:0] rob_tag_t;

	typedef logic [`RETIRE_W-1:0] retire_cnt_t;

endpackage

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# build the reorder buffer testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module rob_tb \
	-f files.f --Mdir obj_dir -o rob_sim \
	|| { echo "verilator build failed"; exit 1; }

output="$(./obj_dir/rob_sim 2>&1)"
echo "$output"

echo "$output" | grep -qx "Simulation completed successfully" \
	&& echo "run passed" \
	|| { echo "run failed"; exit 1; }

//--- test/rob_properties.sv
`timescale 1ns/1ps
`default_nettype none

module rob_properties (
	input wire logic clock,
	input wire logic reset,
	input wire rob_msg_pkg::commit_t commit0,
	input wire rob_msg_pkg::commit_t commit1,
	input wire logic full0,
	input wire logic full1
);

	int violations = 0; // failed assertions so far

	logic redirect_t0; // a mispredicted branch of thread 0 retires this cycle
	logic redirect_t1;
	logic commits_t0;
	logic commits_t1;

	assign redirect_t0 = (commit0.valid & ~commit0.thread & commit0.is_branch & commit0.mispredict)
		| (commit1.valid & ~commit1.thread & commit1.is_branch & commit1.mispredict);
	assign redirect_t1 = (commit0.valid & commit0.thread & commit0.is_branch & commit0.mispredict)
		| (commit1.valid & commit1.thread & commit1.is_branch & commit1.mispredict);
	assign commits_t0 = (commit0.valid & ~commit0.thread) | (commit1.valid & ~commit1.thread);
	assign commits_t1 = (commit0.valid & commit0.thread) | (commit1.valid & commit1.thread);

	commit1_needs_commit0: assert property (@(posedge clock) disable iff (reset)
		commit1.valid |-> commit0.valid)
	else
	begin
		violations++;
		$error("commit1 valid while commit0 is not");
	end

	quiet_after_reset: assert property (@(posedge clock)
		$fell(reset) |-> !commit0.valid && !commit1.valid && !full0 && !full1)
	else
	begin
		violations++;
		$error("outputs not idle in the first cycle after reset");
	end

	// the flushed queue is empty, so that thread cannot commit in the next cycle
	no_commit_after_flush_t0: assert property (@(posedge clock) disable iff (reset)
		redirect_t0 |=> !commits_t0)
	else
	begin
		violations++;
		$error("thread 0 committed a discarded entry after its flush");
	end

	no_commit_after_flush_t1: assert property (@(posedge clock) disable iff (reset)
		redirect_t1 |=> !commits_t1)
	else
	begin
		violations++;
		$error("thread 1 committed a discarded entry after its flush");
	end

endmodule

`default_nettype wire

//--- test/rob_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_consts.svh"

module rob_tb;

	localparam int clock_period = 10;
	localparam int reset_cycles = 10;
	localparam int seed_value = 35967;
	localparam int test_count = 6;
	localparam int cycles_per_test = 60; // reset plus the longest directed sequence
	localparam int margin_cycles = 200;
	localparam int timeout_ns = (test_count * cycles_per_test + margin_cycles) * clock_period;
	localparam int commit_wait_limit = 40;

	logic clock;
	logic reset;
	rob_msg_pkg::dispatch_inst_t dispatch0;
	rob_msg_pkg::dispatch_inst_t dispatch1;
	logic dispatch_thread;
	rob_types_pkg::rob_tag_t tag0;
	rob_types_pkg::rob_tag_t tag1;
	rob_msg_pkg::complete_t complete0;
	rob_msg_pkg::complete_t complete1;
	rob_msg_pkg::commit_t commit0;
	rob_msg_pkg::commit_t commit1;
	logic full0;
	logic full1;

	int seed;
	int errors;
	int checks;
	int tests_run;
	int tests_failed;
	int errors_at_start;
	string test_name;

	rob_top dut0 (
		.clock(clock),
		.reset(reset),
		.dispatch0(dispatch0),
		.dispatch1(dispatch1),
		.dispatch_thread(dispatch_thread),
		.tag0(tag0),
		.tag1(tag1),
		.complete0(complete0),
		.complete1(complete1),
		.commit0(commit0),
		.commit1(commit1),
		.full0(full0),
		.full1(full1)
	);

	bind rob_top rob_properties props0 (
		.clock(clock),
		.reset(reset),
		.commit0(commit0),
		.commit1(commit1),
		.full0(full0),
		.full1(full1)
	);

	always #(clock_period / 2) clock = ~clock;

	task automatic check_value(input string what, input logic [63:0] expected,
		input logic [63:0] actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("ERROR %s: %s expected %0h actual %0h", test_name, what, expected, actual);
		end
	endtask

	task automatic tick;
		@(posedge clock);
		#1; // inputs change just after the edge
	endtask

	task automatic idle_inputs;
		dispatch0 = '0;
		dispatch1 = '0;
		dispatch_thread = 1'b0;
		complete0 = '0;
		complete1 = '0;
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		errors_at_start = errors;
		idle_inputs();
		reset = 1'b1;
		repeat (reset_cycles) tick();
		reset = 1'b0;
	endtask

	task automatic end_test;
		tests_run++;
		if (errors > errors_at_start)
		begin
			tests_failed++;
			$display("test %s failed with %0d errors", test_name, errors - errors_at_start);
		end
		else
			$display("test %s passed", test_name);
	endtask

	function automatic rob_msg_pkg::dispatch_inst_t make_inst(input rob_types_pkg::pc_t pc,
		input logic is_branch);
		rob_msg_pkg::dispatch_inst_t d;
		d.valid = 1'b1;
		d.pc = pc;
		d.arn = pc[6:2]; // register numbers follow the pc, easy to spot in waves
		d.prn = {1'b1, pc[6:2]}; // top bit keeps prn apart from arn
		d.is_branch = is_branch;
		return d;
	endfunction

	function automatic rob_msg_pkg::complete_t make_done(input rob_types_pkg::rob_tag_t tag,
		input logic mispredict, input rob_types_pkg::pc_t target_pc);
		rob_msg_pkg::complete_t c;
		c.valid = 1'b1;
		c.tag = tag;
		c.mispredict = mispredict;
		c.target_pc = target_pc;
		return c;
	endfunction

	// tags are read in the cycle before the accepting edge
	task automatic dispatch(input logic thread, input rob_msg_pkg::dispatch_inst_t d0,
		input rob_msg_pkg::dispatch_inst_t d1, output rob_types_pkg::rob_tag_t t0,
		output rob_types_pkg::rob_tag_t t1);
		dispatch_thread = thread;
		dispatch0 = d0;
		dispatch1 = d1;
		#1;
		t0 = tag0;
		t1 = tag1;
		tick();
		dispatch0 = '0;
		dispatch1 = '0;
	endtask

	task automatic complete_pair(input rob_msg_pkg::complete_t c0,
		input rob_msg_pkg::complete_t c1);
		complete0 = c0;
		complete1 = c1;
		tick();
		complete0 = '0;
		complete1 = '0;
	endtask

	task automatic after_reset;
		rob_types_pkg::rob_tag_t t0;
		rob_types_pkg::rob_tag_t t1;
		begin_test("after_reset");
		check_value("commit0.valid", 0, commit0.valid);
		check_value("commit1.valid", 0, commit1.valid);
		check_value("full0", 0, full0);
		check_value("full1", 0, full1);
		dispatch(1'b0, make_inst(64'h1000, 1'b0), make_inst(64'h1004, 1'b0), t0, t1);
		check_value("tag0", 0, t0);
		check_value("tag1", 1, t1);
		end_test();
	endtask

	task automatic in_order_commit;
		rob_types_pkg::rob_tag_t t0;
		rob_types_pkg::rob_tag_t t1;
		begin_test("in_order_commit");
		dispatch(1'b0, make_inst(64'h2000, 1'b0), make_inst(64'h2004, 1'b0), t0, t1);
		complete_pair(make_done(t1, 1'b0, '0), '0); // younger one finishes first
		repeat (3)
		begin
			check_value("commit0.valid with head pending", 0, commit0.valid);
			tick();
		end
		complete_pair(make_done(t0, 1'b0, '0), '0);
		check_value("commit0.valid", 1, commit0.valid);
		check_value("commit0.pc", 64'h2000, commit0.pc);
		check_value("commit1.valid", 1, commit1.valid);
		check_value("commit1.thread", 0, commit1.thread);
		check_value("commit1.pc", 64'h2004, commit1.pc);
		check_value("commit1.arn", 5'h01, commit1.arn);
		check_value("commit1.prn", 6'h21, commit1.prn);
		check_value("commit1.is_branch", 0, commit1.is_branch);
		tick();
		check_value("commit0.valid after retire", 0, commit0.valid);
		end_test();
	endtask

	task automatic cross_thread_fill;
		rob_types_pkg::rob_tag_t a0;
		rob_types_pkg::rob_tag_t a1;
		rob_types_pkg::rob_tag_t b0;
		rob_types_pkg::rob_tag_t b1;
		begin_test("cross_thread_fill");
		dispatch(1'b0, make_inst(64'h3000, 1'b0), make_inst(64'h3004, 1'b0), a0, a1);
		dispatch(1'b1, make_inst(64'h3100, 1'b0), '0, b0, b1);
		complete_pair(make_done(a0, 1'b0, '0), make_done(b0, 1'b0, '0));
		check_value("commit0.valid", 1, commit0.valid);
		check_value("commit0.thread", 0, commit0.thread);
		check_value("commit0.pc", 64'h3000, commit0.pc);
		check_value("commit1.valid", 1, commit1.valid);
		check_value("commit1.thread", 1, commit1.thread);
		check_value("commit1.pc", 64'h3100, commit1.pc);
		tick();
		check_value("commit0.valid with second pending", 0, commit0.valid);
		end_test();
	endtask

	task automatic full_backpressure;
		rob_types_pkg::rob_tag_t t0;
		rob_types_pkg::rob_tag_t t1;
		begin_test("full_backpressure");
		for (int i = 0; i < 4; i++)
		begin
			check_value("full1 before pair", 0, full1);
			dispatch(1'b1, make_inst(64'h4000 + 64'(8 * i), 1'b0),
				make_inst(64'h4004 + 64'(8 * i), 1'b0), t0, t1);
			check_value("tag0", 64'(8 + 2 * i), t0);
			check_value("tag1", 64'(9 + 2 * i), t1);
		end
		check_value("full1 after four pairs", 1, full1);
		dispatch(1'b1, make_inst(64'h5000, 1'b0), '0, t0, t1); // must be dropped
		check_value("full1 still high", 1, full1);
		complete_pair(make_done(4'h8, 1'b0, '0), make_done(4'h9, 1'b0, '0));
		check_value("commit0.pc", 64'h4000, commit0.pc);
		check_value("commit1.pc", 64'h4004, commit1.pc);
		tick();
		check_value("full1 after commits", 0, full1);
		dispatch(1'b1, make_inst(64'h6000, 1'b0), '0, t0, t1);
		check_value("tag0 after ignored dispatch", 4'h8, t0);
		end_test();
	endtask

	task automatic mispredict_flush;
		rob_types_pkg::rob_tag_t t0;
		rob_types_pkg::rob_tag_t t1;
		begin_test("mispredict_flush");
		dispatch(1'b0, make_inst(64'h7000, 1'b1), make_inst(64'h7004, 1'b0), t0, t1);
		dispatch(1'b0, make_inst(64'h7008, 1'b0), make_inst(64'h700c, 1'b0), t0, t1);
		complete_pair(make_done(4'h3, 1'b0, '0), make_done(4'h2, 1'b0, '0));
		complete_pair(make_done(4'h0, 1'b1, 64'h9000), make_done(4'h1, 1'b0, '0));
		check_value("commit0.valid", 1, commit0.valid);
		check_value("commit0.thread", 0, commit0.thread);
		check_value("commit0.pc", 64'h7000, commit0.pc);
		check_value("commit0.is_branch", 1, commit0.is_branch);
		check_value("commit0.mispredict", 1, commit0.mispredict);
		check_value("commit0.target_pc", 64'h9000, commit0.target_pc);
		check_value("commit1 from thread 0", 0, commit1.valid & ~commit1.thread);
		tick();
		check_value("commit0.valid after flush", 0, commit0.valid);
		dispatch(1'b0, make_inst(64'h7100, 1'b0), '0, t0, t1);
		check_value("tag0 after flush", 1, t0);
		end_test();
	endtask

	task automatic random_completion;
		rob_types_pkg::rob_tag_t t0;
		rob_types_pkg::rob_tag_t t1;
		rob_types_pkg::pc_t seen [$];
		int order [`ROB_DEPTH];
		int next_done;
		int waited;
		int j;
		int swap;
		begin_test("random_completion");
		for (int i = 0; i < `ROB_DEPTH / 2; i++)
			dispatch(1'b0, make_inst(64'h8000 + 64'(8 * i), 1'b0),
				make_inst(64'h8004 + 64'(8 * i), 1'b0), t0, t1);
		check_value("full0 with queue occupied", 1, full0);
		for (int i = 0; i < `ROB_DEPTH; i++)
			order[i] = i;
		for (int i = `ROB_DEPTH - 1; i > 0; i--)
		begin
			j = $unsigned($random(seed)) % (i + 1);
			swap = order[i];
			order[i] = order[j];
			order[j] = swap;
		end
		next_done = 0;
		waited = 0;
		// one completion per cycle, commits sampled once per cycle
		while (seen.size() < `ROB_DEPTH && waited < commit_wait_limit)
		begin
			if (next_done < `ROB_DEPTH)
			begin
				complete0 = make_done(rob_types_pkg::rob_tag_t'(order[next_done]), 1'b0, '0);
				next_done++;
			end
			tick();
			complete0 = '0;
			if (commit0.valid)
				seen.push_back(commit0.pc);
			if (commit1.valid)
				seen.push_back(commit1.pc);
			waited++;
		end
		if (seen.size() != `ROB_DEPTH)
		begin
			errors++;
			$display("test %s: only %0d of %0d commits arrived within %0d cycles",
				test_name, seen.size(), `ROB_DEPTH, commit_wait_limit);
		end
		for (int i = 0; i < seen.size(); i++)
			check_value("commit pc in order", 64'h8000 + 64'(4 * i), seen[i]);
		end_test();
	endtask

	initial
	begin
		clock = 1'b0;
		reset = 1'b1;
		idle_inputs();
		seed = seed_value;
		errors = 0;
		checks = 0;
		tests_run = 0;
		tests_failed = 0;
		after_reset();
		in_order_commit();
		cross_thread_fill();
		full_backpressure();
		mispredict_flush();
		random_completion();
		$display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
			tests_run, tests_failed, checks, errors, dut0.props0.violations);
		if (errors == 0 && tests_failed == 0 && dut0.props0.violations == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	initial
	begin
		#(timeout_ns);
		$display("watchdog expired after %0d ns, the tests did not finish", timeout_ns);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire
